// File: common/div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// Datapath sizing
`define DIV_WIDTH  32      // Operand width, power of two, 8 or more
`define DIV_LANES  4       // Divider lanes, power of two
`define DIV_QDEPTH 8       // Result queue entries

// Byte addresses on the Wishbone port
`define DIV_REG_DIVIDEND  5'h00
`define DIV_REG_DIVISOR   5'h04   // Write issues a job
`define DIV_REG_QUOTIENT  5'h08
`define DIV_REG_REMAINDER 5'h0C   // Read pops the head entry
`define DIV_REG_STATUS    5'h10   // Queue count in low bits

`endif

// File: common/div_pkg.sv
`default_nettype none

`include "div_params.svh"

package div_pkg;

    // One operand or result word
    typedef logic [`DIV_WIDTH-1:0] div_word_t;

    // Lane index, wraps naturally over the lanes
    typedef logic [$clog2(`DIV_LANES)-1:0] lane_idx_t;

    // Queue occupancy, 0 up to DIV_QDEPTH inclusive
    typedef logic [$clog2(`DIV_QDEPTH+1)-1:0] qcount_t;

    // Byte address bits 4..0 of the bus
    typedef logic [4:0] wb_adr_t;

endpackage

`default_nettype wire

// File: hdl/wb_div_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module wb_div_regs import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_adr_t   wb_adr,
    input  div_word_t wb_dat_w,
    output div_word_t wb_dat_r,
    output logic      wb_ack,
    output logic      issue_valid,
    output div_word_t issue_dividend,
    output div_word_t issue_divisor,
    input  logic      issue_accept,
    input  qcount_t   q_count,
    input  div_word_t head_quotient,
    input  div_word_t head_remainder,
    output logic      q_pop
);

    logic      bus_req;     // New cycle seen, not yet answered
    logic      wr_dividend;
    logic      wr_divisor;
    logic      rd_remainder;
    logic      q_empty;
    div_word_t rd_data;

    // Ack and pending issue both mask the still-high stb
    assign bus_req      = wb_cyc & wb_stb & ~wb_ack & ~issue_valid;
    assign wr_dividend  = bus_req & wb_we & (wb_adr == `DIV_REG_DIVIDEND);
    assign wr_divisor   = bus_req & wb_we & (wb_adr == `DIV_REG_DIVISOR);
    assign rd_remainder = bus_req & ~wb_we & (wb_adr == `DIV_REG_REMAINDER);
    assign q_empty      = (q_count == '0);

    ////////////////////////////////////////
    // Read mux
    always_comb begin
        case (wb_adr)
            `DIV_REG_DIVIDEND:  rd_data = issue_dividend;
            `DIV_REG_QUOTIENT:  rd_data = q_empty ? '0 : head_quotient;
            `DIV_REG_REMAINDER: rd_data = q_empty ? '0 : head_remainder;
            `DIV_REG_STATUS:    rd_data = div_word_t'(q_count);
            default:            rd_data = '0;   // Unmapped reads as zero
        endcase
    end

    ////////////////////////////////////////
    // Handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack      <= 1'b0;
            issue_valid <= 1'b0;
            q_pop       <= 1'b0;
        end else begin
            // Divisor write waits for the dispatcher, all else acks next cycle
            wb_ack      <= (bus_req & ~wr_divisor) | (issue_valid & issue_accept);
            issue_valid <= wr_divisor | (issue_valid & ~issue_accept);
            q_pop       <= rd_remainder & ~q_empty;   // Lines up with ack
        end
    end

    // Operand and read data registers
    always_ff @(posedge clk) begin
        if (wr_dividend) begin
            issue_dividend <= wb_dat_w;
        end
        if (wr_divisor) begin
            issue_divisor <= wb_dat_w;   // Held while the job is pending
        end
        if (bus_req & ~wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_dispatch import div_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       issue_valid,
    input  div_word_t                  issue_dividend,
    input  div_word_t                  issue_divisor,
    output logic                       issue_accept,
    output logic      [`DIV_LANES-1:0] lane_start,
    output div_word_t [`DIV_LANES-1:0] lane_dividend,
    output div_word_t [`DIV_LANES-1:0] lane_divisor,
    input  logic      [`DIV_LANES-1:0] lane_release
);

    logic [`DIV_LANES-1:0] busy;   // Lane holds a job or an undrained result
    lane_idx_t             issue_ptr;

    // Strict round robin, no skipping past a busy lane
    assign issue_accept = issue_valid & ~busy[issue_ptr];

    always_comb begin
        lane_start            = '0;
        lane_start[issue_ptr] = issue_accept;
    end

    // Same operands to every lane, only the started one latches
    always_comb begin
        for (int i = 0; i < `DIV_LANES; i++) begin
            lane_dividend[i] = issue_dividend;
            lane_divisor[i]  = issue_divisor;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= '0;
            issue_ptr <= '0;
        end else begin
            busy <= (busy | lane_start) & ~lane_release;   // Never both on one lane
            if (issue_accept) begin
                issue_ptr <= issue_ptr + 1'b1;   // Wraps over a power-of-two lane count
            end
        end
    end

endmodule

`default_nettype wire

// File: div_lane/div_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_core import div_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  div_word_t                     dividend,
    input  div_word_t                     divisor,
    input  logic [$clog2(`DIV_WIDTH)-1:0] dividend_clz,
    input  logic [$clog2(`DIV_WIDTH)-1:0] divisor_clz,
    input  logic                          divisor_is_zero,
    output div_word_t                     quotient,
    output div_word_t                     remainder,
    output logic                          done
);

    localparam int W     = `DIV_WIDTH;
    localparam int CLZ_W = $clog2(W);

    logic [CLZ_W-1:0] clz_delta;
    logic             divisor_larger;
    logic             abort;
    div_word_t        shifted_divisor;
    logic [W+1:0]     diff_2x;          // Remainder minus twice the divisor
    logic [W:0]       diff_1x;
    div_word_t        partial;
    logic [1:0]       q_bits;
    logic [CLZ_W-2:0] cycles_left;
    logic             last_cycle;
    logic             running;

    ////////////////////////////////////////
    // Start cycle
    // Borrow means the divisor has more significant bits
    assign {divisor_larger, clz_delta} = {1'b0, divisor_clz} - {1'b0, dividend_clz};
    assign abort = divisor_larger | divisor_is_zero;

    // Even alignment, odd deltas round down
    always_ff @(posedge clk) begin
        if (running) begin
            shifted_divisor <= shifted_divisor >> 2;
        end else begin
            shifted_divisor <= divisor << {clz_delta[CLZ_W-1:1], 1'b0};
        end
    end

    ////////////////////////////////////////
    // Radix-4 step
    assign diff_2x = {2'b00, remainder} - {1'b0, shifted_divisor, 1'b0};
    assign partial = diff_2x[W+1] ? remainder : diff_2x[W-1:0];
    assign diff_1x = {1'b0, partial} - {1'b0, shifted_divisor};
    assign q_bits  = {~diff_2x[W+1], ~diff_1x[W]};   // Set where no borrow

    always_ff @(posedge clk) begin
        if (start) begin
            quotient <= '0;
        end else if (running) begin
            quotient <= {quotient[W-3:0], q_bits};
        end
    end

    // Digit 00 passes the old remainder through partial
    always_ff @(posedge clk) begin
        if (start) begin
            remainder <= dividend;   // Also the abort result
        end else if (running) begin
            remainder <= diff_1x[W] ? partial : diff_1x[W-1:0];
        end
    end

    ////////////////////////////////////////
    // Control
    assign last_cycle = (cycles_left == '0);

    // Reloads every idle cycle, start included
    always_ff @(posedge clk) begin
        if (running) begin
            cycles_left <= cycles_left - 1'b1;
        end else begin
            cycles_left <= clz_delta[CLZ_W-1:1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (start) begin
                running <= ~abort;
            end else if (running & last_cycle) begin
                running <= 1'b0;
            end
            done <= (start & abort) | (running & last_cycle);   // One-cycle pulse
        end
    end

endmodule

`default_nettype wire

// File: div_lane/div_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_lane import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  div_word_t dividend,
    input  div_word_t divisor,
    input  logic      release_res,
    output logic      res_valid,
    output div_word_t quotient,
    output div_word_t remainder
);

    localparam int CLZ_W = $clog2(`DIV_WIDTH);

    div_word_t        dividend_q;
    div_word_t        divisor_q;
    logic [CLZ_W-1:0] dividend_clz;
    logic [CLZ_W-1:0] divisor_clz;
    logic             divisor_is_zero;
    logic             core_start;
    logic             core_done;
    div_word_t        core_quotient;
    div_word_t        core_remainder;

    // Leading zeros, saturating at width-1 so zero and one both give the max
    function automatic logic [CLZ_W-1:0] clz(input div_word_t v);
        logic [CLZ_W-1:0] n;
        logic             hit;
        n   = '0;
        hit = 1'b0;
        for (int i = `DIV_WIDTH - 1; i > 0; i--) begin
            hit = hit | v[i];
            if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    always_ff @(posedge clk) begin
        if (start) begin
            dividend_q <= dividend;
            divisor_q  <= divisor;
        end
    end

    assign dividend_clz    = clz(dividend_q);
    assign divisor_clz     = clz(divisor_q);
    assign divisor_is_zero = (divisor_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            core_start <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            core_start <= start;   // Counts see the latched operands first
            if (core_done) begin
                res_valid <= 1'b1;
            end else if (release_res) begin
                res_valid <= 1'b0;
            end
        end
    end

    // Held until the collector drains it
    always_ff @(posedge clk) begin
        if (core_done) begin
            quotient  <= core_quotient;
            remainder <= core_remainder;
        end
    end

    div_core u_core (
        .clk, .rst,
        .start     (core_start),
        .dividend  (dividend_q),
        .divisor   (divisor_q),
        .dividend_clz, .divisor_clz, .divisor_is_zero,
        .quotient  (core_quotient),
        .remainder (core_remainder),
        .done      (core_done)
    );

endmodule

`default_nettype wire

// File: hdl/div_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_collect import div_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic      [`DIV_LANES-1:0] res_valid,
    input  div_word_t [`DIV_LANES-1:0] lane_quotient,
    input  div_word_t [`DIV_LANES-1:0] lane_remainder,
    output logic      [`DIV_LANES-1:0] lane_release,
    input  logic                       q_pop,
    output qcount_t                    q_count,
    output div_word_t                  head_quotient,
    output div_word_t                  head_remainder
);

    localparam int PTR_W = $clog2(`DIV_QDEPTH);

    div_word_t        quot_mem [`DIV_QDEPTH];
    div_word_t        rem_mem  [`DIV_QDEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    lane_idx_t        drain_ptr;   // Follows the issue order of the dispatcher
    logic             q_full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`DIV_QDEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_full = (q_count == qcount_t'(`DIV_QDEPTH));
    assign push   = res_valid[drain_ptr] & ~q_full;   // Full queue stalls the lane
    assign pop    = q_pop & (q_count != '0);

    always_comb begin
        lane_release            = '0;
        lane_release[drain_ptr] = push;
    end

    assign head_quotient  = quot_mem[rd_ptr];
    assign head_remainder = rem_mem[rd_ptr];

    // Result storage
    always_ff @(posedge clk) begin
        if (push) begin
            quot_mem[wr_ptr] <= lane_quotient[drain_ptr];
            rem_mem[wr_ptr]  <= lane_remainder[drain_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            drain_ptr <= '0;
            q_count   <= '0;
        end else begin
            if (push) begin
                wr_ptr    <= ptr_inc(wr_ptr);
                drain_ptr <= drain_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;   // Push with pop keeps the count
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_unit import div_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_adr_t   wb_adr,
    input  div_word_t wb_dat_w,
    output div_word_t wb_dat_r,
    output logic      wb_ack
);

    // Register block to dispatcher
    logic      issue_valid;
    logic      issue_accept;
    div_word_t issue_dividend;
    div_word_t issue_divisor;

    // Dispatcher to lanes
    logic      [`DIV_LANES-1:0] lane_start;
    div_word_t [`DIV_LANES-1:0] lane_dividend;
    div_word_t [`DIV_LANES-1:0] lane_divisor;

    // Lanes to collector, and release back
    logic      [`DIV_LANES-1:0] res_valid;
    logic      [`DIV_LANES-1:0] lane_release;
    div_word_t [`DIV_LANES-1:0] lane_quotient;
    div_word_t [`DIV_LANES-1:0] lane_remainder;

    // Result queue head
    qcount_t   q_count;
    logic      q_pop;
    div_word_t head_quotient;
    div_word_t head_remainder;

    ////////////////////////////////////////
    // Bus side
    wb_div_regs u_regs (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .issue_valid, .issue_dividend, .issue_divisor, .issue_accept,
        .q_count, .head_quotient, .head_remainder, .q_pop
    );

    div_dispatch u_dispatch (
        .clk, .rst,
        .issue_valid, .issue_dividend, .issue_divisor, .issue_accept,
        .lane_start, .lane_dividend, .lane_divisor, .lane_release
    );

    ////////////////////////////////////////
    // Lane array
    for (genvar i = 0; i < `DIV_LANES; i++) begin : g_lane
        div_lane u_lane (
            .clk, .rst,
            .start       (lane_start[i]),
            .dividend    (lane_dividend[i]),
            .divisor     (lane_divisor[i]),
            .release_res (lane_release[i]),
            .res_valid   (res_valid[i]),
            .quotient    (lane_quotient[i]),
            .remainder   (lane_remainder[i])
        );
    end

    div_collect u_collect (
        .clk, .rst,
        .res_valid, .lane_quotient, .lane_remainder, .lane_release,
        .q_pop, .q_count, .head_quotient, .head_remainder
    );

endmodule

`default_nettype wire

// File: bench/div_unit_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_unit_props import div_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    wb_cyc,
    input logic    wb_stb,
    input logic    wb_ack,
    input qcount_t q_count
);

    int unsigned ack_req_fails = 0;
    int unsigned ack_len_fails = 0;
    int unsigned count_fails   = 0;
    int unsigned fail_count;

    assign fail_count = ack_req_fails + ack_len_fails + count_fails;

    // Ack only answers an active cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack high without wb_cyc and wb_stb");
            ack_req_fails++;
        end

    // Single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held longer than one cycle");
            ack_len_fails++;
        end

    count_bound: assert property (@(posedge clk) disable iff (rst)
        q_count <= qcount_t'(`DIV_QDEPTH))
        else begin
            $error("q_count above the queue depth");
            count_fails++;
        end

endmodule

bind div_unit div_unit_props u_props (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .q_count
);

`default_nettype wire

// File: bench/div_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_unit_tb import div_pkg::*; ();

    localparam int BUS_TIMEOUT = 200;                       // Cycles allowed for one ack
    localparam int POLL_LIMIT  = 100;                       // Status reads per wait
    localparam int CAPACITY    = `DIV_LANES + `DIV_QDEPTH;  // Jobs held with no reads

    logic      clk;
    logic      rst;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_adr_t   wb_adr;
    div_word_t wb_dat_w;
    div_word_t wb_dat_r;
    logic      wb_ack;

    logic [31:0] lcg_state;
    div_word_t   exp_quot[$];   // Reference results in issue order
    div_word_t   exp_rem[$];

    div_unit dut (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random source
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Random significant width, zero about one time in sixteen
    function automatic div_word_t rand_operand();
        logic [31:0] r;
        logic [31:0] v;
        r = next_rand();
        v = next_rand();
        if (r[31:28] == 4'h0) begin
            return '0;
        end
        return v >> r[20:16];
    endfunction

    ////////////////////////////////////////
    // Failure and compare
    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_quotient(input div_word_t got, input div_word_t exp);
        if (got !== exp) begin
            $display("Error: quotient got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_remainder(input div_word_t got, input div_word_t exp);
        if (got !== exp) begin
            $display("Error: remainder got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input qcount_t got, input qcount_t exp);
        if (got !== exp) begin
            $display("Error: q_count got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////
    // Wishbone master
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);   // Ack and read data settled mid-cycle
            cycles++;
            if (cycles > BUS_TIMEOUT) begin
                $display("Timeout: the bus gave no ack within %0d cycles", BUS_TIMEOUT);
                stop_on_failure();
            end
        end while (wb_ack !== 1'b1);
    endtask

    task automatic wb_write(input wb_adr_t adr, input div_word_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);   // Strobe drops the cycle after ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_adr_t adr, output div_word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Job level
    task automatic read_count(output qcount_t count);
        div_word_t data;
        wb_read(`DIV_REG_STATUS, data);
        count = qcount_t'(data);
    endtask

    task automatic wait_count(input qcount_t want, output qcount_t count);
        int polls;
        polls = 0;
        read_count(count);
        while (count < want) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                $display("Timeout: queue never reached %0d results", want);
                stop_on_failure();
            end
            read_count(count);
        end
    endtask

    task automatic issue_job(input div_word_t a, input div_word_t b);
        wb_write(`DIV_REG_DIVIDEND, a);
        wb_write(`DIV_REG_DIVISOR, b);   // May stall on a busy lane
        if (b == '0) begin
            exp_quot.push_back('0);   // Zero divisor keeps the dividend
            exp_rem.push_back(a);
        end else begin
            exp_quot.push_back(a / b);
            exp_rem.push_back(a % b);
        end
    endtask

    task automatic read_result();
        qcount_t   count;
        div_word_t quot;
        div_word_t rem;
        wait_count(qcount_t'(1), count);
        wb_read(`DIV_REG_QUOTIENT, quot);
        wb_read(`DIV_REG_REMAINDER, rem);   // Pops the head
        check_quotient(quot, exp_quot.pop_front());
        check_remainder(rem, exp_rem.pop_front());
    endtask

    task automatic single_job(input div_word_t a, input div_word_t b);
        qcount_t count;
        issue_job(a, b);
        wait_count(qcount_t'(1), count);
        check_count(count, qcount_t'(1));
        read_result();
        read_count(count);
        check_count(count, '0);
    endtask

    initial begin
        qcount_t     count;
        int          issued;
        logic [31:0] r;
        lcg_state = 32'd63229;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Single random divisions
        repeat (20) begin
            single_job(rand_operand(), rand_operand());
        end

        // Edge operands
        single_job(32'h1234_5678, 32'h0);
        single_job(32'h0000_0005, 32'h0000_0009);
        single_job(32'h1234_5678, 32'h1);
        single_job(32'hDEAD_BEEF, 32'hDEAD_BEEF);
        single_job(32'hFFFF_FFFF, 32'hFFFF_FFFF);
        single_job(32'hFFFF_FFFF, 32'h1);
        single_job(32'hFFFF_FFFF, 32'h3);
        single_job(32'h8000_0000, 32'h8000_0000);
        single_job(32'h8000_0000, 32'h7);
        single_job(32'hFFFF_FFFF, 32'h8000_0000);

        // Long job first so later lanes finish before it
        issue_job(32'hFFFF_FFFF, 32'h1);
        issue_job(32'h0000_FFFF, 32'h3);
        issue_job(32'h0000_00F0, 32'h7);
        issue_job(32'h0000_0005, 32'h9);   // Aborts at once
        wait_count(qcount_t'(`DIV_LANES), count);
        repeat (`DIV_LANES) begin
            read_result();
        end

        // Fill queue and lanes then drain in order
        repeat (CAPACITY) begin
            issue_job(rand_operand(), rand_operand());
        end
        wait_count(qcount_t'(`DIV_QDEPTH), count);
        repeat (50) @(posedge clk);
        read_count(count);
        check_count(count, qcount_t'(`DIV_QDEPTH));   // Lanes hold the rest
        repeat (CAPACITY) begin
            read_result();
        end

        // Random mix of issues and reads
        issued = 0;
        while (issued < 300) begin
            r = next_rand();
            if (exp_quot.size() == CAPACITY || (exp_quot.size() != 0 && r[31])) begin
                read_result();
            end else begin
                issue_job(rand_operand(), rand_operand());
                issued++;
            end
        end
        while (exp_quot.size() != 0) begin
            read_result();
        end

        // Bus and queue properties
        if (dut.u_props.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Bus or queue properties failed %0d times", dut.u_props.fail_count);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/div_pkg.sv
hdl/wb_div_regs.sv
hdl/div_dispatch.sv
div_lane/div_core.sv
div_lane/div_lane.sv
hdl/div_collect.sv
hdl/div_unit.sv
bench/div_unit_props.sv
bench/div_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the divider testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module div_unit_tb -o div_unit_sim

./obj_dir/div_unit_sim 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
